// File: sim.f
+incdir+hw
hw/md5_pkg.sv
hw/md5_control.sv
hw/md5_block_pad.sv
hw/md5_constants.sv
hw/md5_step.sv
hw/md5_state.sv
hw/md5_core.sv
verification/tb_md5_core.sv

// File: Bender.yml
package:
  name: md5_core

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/md5_pkg.sv
      - hw/md5_control.sv
      - hw/md5_block_pad.sv
      - hw/md5_constants.sv
      - hw/md5_step.sv
      - hw/md5_state.sv
      - hw/md5_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_md5_core.sv

// File: verification/tb_md5_core.sv
`timescale 1ns/10ps

`include "md5_params.svh"

module tb_md5_core;

   // ----------------------------------------
   // run sizing
   // ----------------------------------------
   localparam int N_VEC       = 7;
   // entries whose digests are taken from rfc 1321 or known lists
   localparam int N_KNOWN     = 5;
   // accept edge through turnaround, plus the drive cycle
   localparam int HASH_CYCLES = 68;
   localparam int MAX_GAP     = 12;
   localparam int RUN_CYCLES  = HASH_CYCLES + MAX_GAP + 2;
   // table runs, busy rerun, aborted run, recovery run
   localparam int N_RUNS      = N_VEC + 3;
   localparam int QUIET_CYC   = 80;
   localparam int CYCLE_LIMIT = 2 * (N_RUNS * RUN_CYCLES + QUIET_CYC + 20);
   // edge after accept where the busy pulse goes in
   localparam int BUSY_EDGE   = 20;
   localparam int ABORT_EDGE  = 30;
   localparam logic [31:0] SEED = 32'h85d54a62;
   // md5 rotate amounts, entry 4*round + (i mod 4), entry 0 in the low bits
   localparam logic [79:0] ROT = {5'd21, 5'd15, 5'd10, 5'd6,  5'd23, 5'd16, 5'd11, 5'd4,
                                  5'd20, 5'd14, 5'd9,  5'd5,  5'd22, 5'd17, 5'd12, 5'd7};

   logic                    clk;
   logic                    reset;
   logic [`MD5_MSG_W-1:0]   msg_in;
   logic [`MD5_WIDTH_W-1:0] msg_in_width;
   logic                    msg_in_valid;
   logic [127:0]            msg_output;
   logic                    msg_out_valid;
   logic                    ready;

   // vector table
   logic [127:0]            msg_tab   [N_VEC];
   logic [7:0]              width_tab [N_VEC];
   logic [127:0]            exp_tab   [N_VEC];
   int                      cycle_count = 0;

   md5_core DUT (
      .clk           (clk),
      .reset         (reset),
      .msg_in        (msg_in),
      .msg_in_width  (msg_in_width),
      .msg_in_valid  (msg_in_valid),
      .msg_output    (msg_output),
      .msg_out_valid (msg_out_valid),
      .ready         (ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // run limit
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
         $display("Test FAILED");
         $fatal(1, "run timed out");
      end
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // first character moves to bits 127:120
   function automatic logic [127:0] left_align(input logic [127:0] text, input int nbytes);
      return text << (8 * (16 - nbytes));
   endfunction

   // bytes of msg_in beyond the message
   function automatic logic [127:0] unused_mask(input int nbytes);
      logic [127:0] keep;
      keep = ~(128'h0) << (8 * (16 - nbytes));
      return ~keep;
   endfunction

   function automatic logic [31:0] swap_bytes(input logic [31:0] w);
      return {w[7:0], w[15:8], w[23:16], w[31:24]};
   endfunction

   // behavioral md5 of one short message, straight from rfc 1321
   function automatic logic [127:0] md5_model(input logic [127:0] msg, input int nbytes);
      logic [7:0]  blk [64];
      logic [31:0] x   [16];
      logic [31:0] a, b, c, d, f, k, sum, t;
      int          g, s, hi, lo;
      real         r;
      for (int j = 0; j < 64; j++)
         blk[j] = 8'h00;
      for (int j = 0; j < nbytes; j++)
         blk[j] = msg[127-8*j -: 8];
      blk[nbytes] = 8'h80;
      // bit count always fits the low length byte
      blk[56] = 8'(8 * nbytes);
      for (int j = 0; j < 16; j++)
         x[j] = {blk[4*j+3], blk[4*j+2], blk[4*j+1], blk[4*j]};
      a = 32'h67452301;
      b = 32'hefcdab89;
      c = 32'h98badcfe;
      d = 32'h10325476;
      for (int i = 0; i < 64; i++) begin
         case (i / 16)
            0: begin
               f = (b & c) | (~b & d);
               g = i;
            end
            1: begin
               f = (d & b) | (~d & c);
               g = (5 * i + 1) % 16;
            end
            2: begin
               f = b ^ c ^ d;
               g = (3 * i + 5) % 16;
            end
            default: begin
               f = c ^ (b | ~d);
               g = (7 * i) % 16;
            end
         endcase
         // constant floor(abs(sin(i+1)) * 2^32), built in two halves
         r = $sin(i + 1);
         if (r < 0.0)
            r = -r;
         r = r * 4294967296.0;
         hi = $rtoi(r / 65536.0);
         lo = $rtoi(r - real'(hi) * 65536.0);
         k = {hi[15:0], lo[15:0]};
         s = ROT[5*(4*(i/16) + i%4) +: 5];
         sum = a + f + k + x[g];
         t = d;
         d = c;
         c = b;
         b = b + ((sum << s) | (sum >> (32 - s)));
         a = t;
      end
      a = a + 32'h67452301;
      b = b + 32'hefcdab89;
      c = c + 32'h98badcfe;
      d = d + 32'h10325476;
      return {swap_bytes(a), swap_bytes(b), swap_bytes(c), swap_bytes(d)};
   endfunction

   task automatic build_table();
      logic [127:0] model;
      msg_tab[0] = 128'h0;
      width_tab[0] = 8'd0;
      exp_tab[0] = 128'hd41d8cd98f00b204e9800998ecf8427e;
      msg_tab[1] = left_align("a", 1);
      width_tab[1] = 8'd8;
      exp_tab[1] = 128'h0cc175b9c0f1b6a831c399e269772661;
      msg_tab[2] = left_align("abc", 3);
      width_tab[2] = 8'd24;
      exp_tab[2] = 128'h900150983cd24fb0d6963f7d28e17f72;
      msg_tab[3] = left_align("message digest", 14);
      width_tab[3] = 8'd112;
      exp_tab[3] = 128'hf96b697d7cb7938d525a2f31aaf161d0;
      msg_tab[4] = left_align("12345678", 8);
      width_tab[4] = 8'd64;
      exp_tab[4] = 128'h25d55ad283aa400af464c76d713c07ad;
      msg_tab[5] = left_align("fifteen bytes!!", 15);
      width_tab[5] = 8'd120;
      msg_tab[6] = left_align("0123456789abcdef", 16);
      width_tab[6] = 8'd128;
      // model must agree with the published digests before it fills the rest
      for (int i = 0; i < N_VEC; i++) begin
         model = md5_model(msg_tab[i], width_tab[i] / 8);
         if (i < N_KNOWN)
            check_value(model, exp_tab[i], "reference model against known digest");
         else
            exp_tab[i] = model;
      end
   endtask

   // ----------------------------------------
   // one hash with latency and ready checks
   // ----------------------------------------
   task automatic run_hash(input int idx, input bit busy_pulse);
      int           edges;
      bit           got;
      logic [127:0] junk;
      junk = {$urandom, $urandom, $urandom, $urandom};
      @(posedge clk);
      #1;
      check_value(ready, 1'b1, "ready before a new message");
      // junk past the message must not reach the block
      msg_in = msg_tab[idx] | (junk & unused_mask(width_tab[idx] / 8));
      msg_in_width = width_tab[idx];
      msg_in_valid = 1'b1;
      // acceptance edge
      @(posedge clk);
      #1;
      msg_in_valid = 1'b0;
      edges = 0;
      got = 1'b0;
      while (!got) begin
         @(negedge clk);
         if (msg_out_valid) begin
            got = 1'b1;
         end else begin
            check_value(ready, 1'b0, "ready while hashing");
            @(posedge clk);
            edges++;
            #1;
            // different message while busy, must fall away
            if (busy_pulse && edges == BUSY_EDGE) begin
               msg_in = ~msg_in;
               msg_in_width = 8'd128;
               msg_in_valid = 1'b1;
            end else begin
               msg_in_valid = 1'b0;
            end
         end
      end
      check_value(edges, 65, "edges from accept to digest valid");
      check_value(ready, 1'b0, "ready during the digest cycle");
      check_value(msg_output, exp_tab[idx], $sformatf("digest of vector %0d", idx));
      // turnaround edge
      @(posedge clk);
      #1;
      @(negedge clk);
      check_value(msg_out_valid, 1'b0, "digest valid held past one cycle");
      check_value(ready, 1'b1, "ready after the turnaround");
   endtask

   // start a hash and kill it with reset
   task automatic abort_with_reset(input int idx);
      @(posedge clk);
      #1;
      check_value(ready, 1'b1, "ready before the aborted message");
      msg_in = msg_tab[idx];
      msg_in_width = width_tab[idx];
      msg_in_valid = 1'b1;
      @(posedge clk);
      #1;
      msg_in_valid = 1'b0;
      repeat (ABORT_EDGE) @(posedge clk);
      #1;
      reset = 1'b1;
      // reset is taken at the next edge
      @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_value(ready, 1'b1, "ready after reset mid-hash");
      check_value(msg_out_valid, 1'b0, "digest valid after reset mid-hash");
      // old hash would have ended inside this window
      repeat (QUIET_CYC) begin
         @(negedge clk);
         check_value(msg_out_valid, 1'b0, "digest valid from an aborted hash");
         check_value(ready, 1'b1, "ready after the aborted hash");
      end
   endtask

   task automatic idle_gap();
      int gap;
      gap = $urandom % MAX_GAP;
      repeat (gap) @(posedge clk);
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      void'($urandom(SEED));
      reset = 1'b1;
      msg_in = '0;
      msg_in_width = '0;
      msg_in_valid = 1'b0;
      build_table();

      // reset held three cycles
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_value(ready, 1'b1, "ready after reset");
      check_value(msg_out_valid, 1'b0, "digest valid after reset");

      for (int i = 0; i < N_VEC; i++) begin
         idle_gap();
         run_hash(i, 1'b0);
      end

      // busy pulse ignored
      idle_gap();
      run_hash(3, 1'b1);

      // reset mid-hash, then a clean hash
      idle_gap();
      abort_with_reset(5);
      idle_gap();
      run_hash(6, 1'b0);

      $display("Test OK");
      $finish;
   end

endmodule

// File: hw/md5_core.sv
`timescale 1ns/10ps

`include "md5_params.svh"

module md5_core (
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`MD5_MSG_W-1:0]   msg_in,
   input  logic [`MD5_WIDTH_W-1:0] msg_in_width,
   input  logic                    msg_in_valid,
   output md5_pkg::digest_t        msg_output,
   output logic                    msg_out_valid,
   output logic                    ready
);

   import md5_pkg::*;

   // ----------------------------------------
   // control strobes
   // ----------------------------------------
   logic      load;
   logic      step_en;
   logic      finish;
   logic      clear;
   step_t     step;
   md5_func_e func;

   // ----------------------------------------
   // datapath
   // ----------------------------------------
   word_t       m_word;
   word_t       t_const;
   logic [4:0]  shift;
   word_t       new_b;
   word_t       a;
   word_t       b;
   word_t       c;
   word_t       d;

   // sequencer
   md5_control u_control (
      .clk           (clk),
      .reset         (reset),
      .msg_in_valid  (msg_in_valid),
      .load          (load),
      .step_en       (step_en),
      .finish        (finish),
      .clear         (clear),
      .ready         (ready),
      .msg_out_valid (msg_out_valid),
      .step          (step),
      .func          (func)
   );

   // padded block and message word per step
   md5_block_pad u_block_pad (
      .clk          (clk),
      .msg_in       (msg_in),
      .msg_in_width (msg_in_width),
      .load         (load),
      .step         (step),
      .m_word       (m_word)
   );

   // constant and rotate per step
   md5_constants u_constants (
      .step    (step),
      .t_const (t_const),
      .shift   (shift)
   );

   // one compression step
   md5_step u_step (
      .func    (func),
      .a       (a),
      .b       (b),
      .c       (c),
      .d       (d),
      .m_word  (m_word),
      .t_const (t_const),
      .shift   (shift),
      .new_b   (new_b)
   );

   // a..d registers and digest
   md5_state u_state (
      .clk        (clk),
      .reset      (reset),
      .load       (load),
      .step_en    (step_en),
      .finish     (finish),
      .clear      (clear),
      .new_b      (new_b),
      .a          (a),
      .b          (b),
      .c          (c),
      .d          (d),
      .msg_output (msg_output)
   );

endmodule

// File: hw/md5_state.sv
`timescale 1ns/10ps

`include "md5_params.svh"

module md5_state (
   input  logic             clk,
   input  logic             reset,
   input  logic             load,
   input  logic             step_en,
   input  logic             finish,
   input  logic             clear,
   input  md5_pkg::word_t   new_b,
   output md5_pkg::word_t   a,
   output md5_pkg::word_t   b,
   output md5_pkg::word_t   c,
   output md5_pkg::word_t   d,
   output md5_pkg::digest_t msg_output
);

   import md5_pkg::*;

   // chaining values taken at load
   word_t saved_a;
   word_t saved_b;
   word_t saved_c;
   word_t saved_d;

   // ----------------------------------------
   // working registers
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         a <= `MD5_INIT_A;
         b <= `MD5_INIT_B;
         c <= `MD5_INIT_C;
         d <= `MD5_INIT_D;
      end else if (step_en) begin
         // rotate the four words, only b is computed
         a <= d;
         b <= new_b;
         c <= b;
         d <= c;
      end else if (finish) begin
         // add back the chaining values
         a <= a + saved_a;
         b <= b + saved_b;
         c <= c + saved_c;
         d <= d + saved_d;
      end
   end

   // copy of a..d at the start of the block
   always_ff @(posedge clk) begin
      if (load) begin
         saved_a <= a;
         saved_b <= b;
         saved_c <= c;
         saved_d <= d;
      end
   end

   // ----------------------------------------
   // digest output
   // ----------------------------------------
   // low byte of a goes out first
   assign msg_output = {
      {<<8{a}},
      {<<8{b}},
      {<<8{c}},
      {<<8{d}}
   };

   // the finish add leaves the datapath with a valid digest
   a_finish_after_steps: assert property (@(posedge clk) disable iff (reset)
      finish |-> $past(step_en));

endmodule

// File: hw/md5_step.sv
`timescale 1ns/10ps

module md5_step (
   input  md5_pkg::md5_func_e func,
   input  md5_pkg::word_t     a,
   input  md5_pkg::word_t     b,
   input  md5_pkg::word_t     c,
   input  md5_pkg::word_t     d,
   input  md5_pkg::word_t     m_word,
   input  md5_pkg::word_t     t_const,
   input  logic [4:0]         shift,
   output md5_pkg::word_t     new_b
);

   import md5_pkg::*;

   word_t       f_out;
   word_t       sum;
   // sum twice side by side, so a left shift leaves the rotate on top
   logic [63:0] rot_full;
   word_t       rotated;

   // ----------------------------------------
   // round functions
   // ----------------------------------------
   always_comb begin
      case (func)
         // b picks c or d
         FUNC_F:  f_out = (b & c) | (~b & d);
         // d picks b or c
         FUNC_G:  f_out = (b & d) | (c & ~d);
         // parity
         FUNC_H:  f_out = b ^ c ^ d;
         default: f_out = c ^ (b | ~d);
      endcase
   end

   // four way add, modulo 2^32
   assign sum = a + f_out + m_word + t_const;

   // rotate left
   assign rot_full = {sum, sum} << shift;
   assign rotated  = rot_full[63:32];

   // result becomes the new b
   assign new_b = b + rotated;

endmodule

// File: hw/md5_constants.sv
`timescale 1ns/10ps

module md5_constants (
   input  md5_pkg::step_t step,
   output md5_pkg::word_t t_const,
   output logic [4:0]     shift
);

   import md5_pkg::*;

   // ----------------------------------------
   // sine table, floor(abs(sin(i+1)) * 2^32)
   // ----------------------------------------
   always_comb begin
      case (step)
         // round 1
         6'd0:  t_const = 32'hd76aa478;
         6'd1:  t_const = 32'he8c7b756;
         6'd2:  t_const = 32'h242070db;
         6'd3:  t_const = 32'hc1bdceee;
         6'd4:  t_const = 32'hf57c0faf;
         6'd5:  t_const = 32'h4787c62a;
         6'd6:  t_const = 32'ha8304613;
         6'd7:  t_const = 32'hfd469501;
         6'd8:  t_const = 32'h698098d8;
         6'd9:  t_const = 32'h8b44f7af;
         6'd10: t_const = 32'hffff5bb1;
         6'd11: t_const = 32'h895cd7be;
         6'd12: t_const = 32'h6b901122;
         6'd13: t_const = 32'hfd987193;
         6'd14: t_const = 32'ha679438e;
         6'd15: t_const = 32'h49b40821;
         // round 2
         6'd16: t_const = 32'hf61e2562;
         6'd17: t_const = 32'hc040b340;
         6'd18: t_const = 32'h265e5a51;
         6'd19: t_const = 32'he9b6c7aa;
         6'd20: t_const = 32'hd62f105d;
         6'd21: t_const = 32'h02441453;
         6'd22: t_const = 32'hd8a1e681;
         6'd23: t_const = 32'he7d3fbc8;
         6'd24: t_const = 32'h21e1cde6;
         6'd25: t_const = 32'hc33707d6;
         6'd26: t_const = 32'hf4d50d87;
         6'd27: t_const = 32'h455a14ed;
         6'd28: t_const = 32'ha9e3e905;
         6'd29: t_const = 32'hfcefa3f8;
         6'd30: t_const = 32'h676f02d9;
         6'd31: t_const = 32'h8d2a4c8a;
         // round 3
         6'd32: t_const = 32'hfffa3942;
         6'd33: t_const = 32'h8771f681;
         6'd34: t_const = 32'h6d9d6122;
         6'd35: t_const = 32'hfde5380c;
         6'd36: t_const = 32'ha4beea44;
         6'd37: t_const = 32'h4bdecfa9;
         6'd38: t_const = 32'hf6bb4b60;
         6'd39: t_const = 32'hbebfbc70;
         6'd40: t_const = 32'h289b7ec6;
         6'd41: t_const = 32'heaa127fa;
         6'd42: t_const = 32'hd4ef3085;
         6'd43: t_const = 32'h04881d05;
         6'd44: t_const = 32'hd9d4d039;
         6'd45: t_const = 32'he6db99e5;
         6'd46: t_const = 32'h1fa27cf8;
         6'd47: t_const = 32'hc4ac5665;
         // round 4
         6'd48: t_const = 32'hf4292244;
         6'd49: t_const = 32'h432aff97;
         6'd50: t_const = 32'hab9423a7;
         6'd51: t_const = 32'hfc93a039;
         6'd52: t_const = 32'h655b59c3;
         6'd53: t_const = 32'h8f0ccc92;
         6'd54: t_const = 32'hffeff47d;
         6'd55: t_const = 32'h85845dd1;
         6'd56: t_const = 32'h6fa87e4f;
         6'd57: t_const = 32'hfe2ce6e0;
         6'd58: t_const = 32'ha3014314;
         6'd59: t_const = 32'h4e0811a1;
         6'd60: t_const = 32'hf7537e82;
         6'd61: t_const = 32'hbd3af235;
         6'd62: t_const = 32'h2ad7d2bb;
         default: t_const = 32'heb86d391;
      endcase
   end

   // ----------------------------------------
   // rotate amounts, four per round
   // ----------------------------------------
   always_comb begin
      case ({step[5:4], step[1:0]})
         4'b00_00: shift = 5'd7;
         4'b00_01: shift = 5'd12;
         4'b00_10: shift = 5'd17;
         4'b00_11: shift = 5'd22;
         4'b01_00: shift = 5'd5;
         4'b01_01: shift = 5'd9;
         4'b01_10: shift = 5'd14;
         4'b01_11: shift = 5'd20;
         4'b10_00: shift = 5'd4;
         4'b10_01: shift = 5'd11;
         4'b10_10: shift = 5'd16;
         4'b10_11: shift = 5'd23;
         4'b11_00: shift = 5'd6;
         4'b11_01: shift = 5'd10;
         4'b11_10: shift = 5'd15;
         default:  shift = 5'd21;
      endcase
   end

endmodule

// File: hw/md5_block_pad.sv
`timescale 1ns/10ps

`include "md5_params.svh"

module md5_block_pad (
   input  logic                    clk,
   input  logic [`MD5_MSG_W-1:0]   msg_in,
   input  logic [`MD5_WIDTH_W-1:0] msg_in_width,
   input  logic                    load,
   input  md5_pkg::step_t          step,
   output md5_pkg::word_t          m_word
);

   import md5_pkg::*;

   // whole bytes in the message
   logic [4:0] n_bytes;
   block_t     pad_block;
   block_t     block_q;
   logic [3:0] phase;
   logic [3:0] msg_idx;

   assign n_bytes = msg_in_width[`MD5_WIDTH_W-1:3];

   // ----------------------------------------
   // padding
   // ----------------------------------------
   // byte k of the block lives at bits 8k+7:8k,
   // so each word comes out little endian
   always_comb begin
      pad_block = '0;
      for (int k = 0; k < `MD5_MSG_W/8; k++) begin
         // message byte k, first byte at the top of msg_in
         if (k < n_bytes)
            pad_block[8*k +: 8] = msg_in[`MD5_MSG_W-1-8*k -: 8];
      end
      // marker right behind the last message byte
      pad_block[8*n_bytes +: 8] = 8'h80;
      // bit length, words 14 and 15, low word first
      pad_block[448 +: 64] = {{(64-`MD5_WIDTH_W){1'b0}}, msg_in_width};
   end

   // block held for the whole hash
   always_ff @(posedge clk) begin
      if (load)
         block_q <= pad_block;
   end

   // ----------------------------------------
   // message schedule
   // ----------------------------------------
   assign phase = step[3:0];

   // word index per round, all mod 16
   always_comb begin
      case (step[5:4])
         2'd0:    msg_idx = phase;
         2'd1:    msg_idx = 4'((5 * phase) + 1);
         2'd2:    msg_idx = 4'((3 * phase) + 5);
         default: msg_idx = 4'(7 * phase);
      endcase
   end

   assign m_word = block_q[`MD5_WORD_W*msg_idx +: `MD5_WORD_W];

   // only whole bytes up to the block limit fit one block
   a_width_ok: assert property (@(posedge clk)
      load |-> (msg_in_width <= `MD5_MSG_W) && (msg_in_width[2:0] == 3'b000));

endmodule

// File: hw/md5_control.sv
`timescale 1ns/10ps

`include "md5_params.svh"

module md5_control (
   input  logic                clk,
   input  logic                reset,
   input  logic                msg_in_valid,
   output logic                load,
   output logic                step_en,
   output logic                finish,
   output logic                clear,
   output logic                ready,
   output logic                msg_out_valid,
   output md5_pkg::step_t      step,
   output md5_pkg::md5_func_e  func
);

   import md5_pkg::*;

   md5_state_e state;
   md5_state_e state_next;

   // ----------------------------------------
   // strobes, all decoded from the state
   // ----------------------------------------
   assign ready   = (state == IDLE);
   // accept only while idle, busy pulses fall away here
   assign load    = ready && msg_in_valid;
   assign step_en = (state == ROUNDS);
   assign finish  = (state == FINISH);
   // turnaround cycle puts the datapath back to initial values
   assign clear   = (state == TURN_ARND);

   // round number picks the function
   assign func = md5_func_e'(step[5:4]);

   // next state
   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (msg_in_valid)
               state_next = ROUNDS;
         end
         ROUNDS: begin
            // last step of round 4
            if (step == step_t'(`MD5_STEPS-1))
               state_next = FINISH;
         end
         FINISH:    state_next = TURN_ARND;
         TURN_ARND: state_next = IDLE;
         default:   state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   // step counter, zeroed at load and wraps after step 63
   always_ff @(posedge clk) begin
      if (reset || load) begin
         step <= '0;
      end else if (step_en) begin
         step <= step + 1'b1;
      end
   end

   // digest valid the cycle after the finish add
   always_ff @(posedge clk) begin
      if (reset) begin
         msg_out_valid <= 1'b0;
      end else begin
         msg_out_valid <= finish;
      end
   end

   // ----------------------------------------
   // checks
   // ----------------------------------------
   // accepted message reaches the finish add after all steps
   a_load_idle: assert property (@(posedge clk) disable iff (reset)
      load |-> ##(`MD5_STEPS+1) finish);

   // single cycle digest strobe
   a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
      msg_out_valid |=> !msg_out_valid);

endmodule

// File: hw/md5_pkg.sv
`include "md5_params.svh"

package md5_pkg;

   // one md5 word
   typedef logic [`MD5_WORD_W-1:0] word_t;

   // padded block, word j sits at bits 32j+31:32j
   typedef logic [`MD5_BLOCK_W-1:0] block_t;

   // digest, first byte in the top bits
   typedef logic [4*`MD5_WORD_W-1:0] digest_t;

   // step index, upper two bits round, lower four bits phase
   typedef logic [$clog2(`MD5_STEPS)-1:0] step_t;

   // sequencer states
   typedef enum logic [1:0] {
      IDLE,
      ROUNDS,
      FINISH,
      TURN_ARND
   } md5_state_e;

   // round function select, follows the round number
   typedef enum logic [1:0] {
      FUNC_F,
      FUNC_G,
      FUNC_H,
      FUNC_I
   } md5_func_e;

endpackage

// File: hw/md5_params.svh
`ifndef MD5_PARAMS_SVH
`define MD5_PARAMS_SVH

// ----------------------------------------
// datapath sizes
// ----------------------------------------

// one md5 word
`define MD5_WORD_W   32
// one padded block
`define MD5_BLOCK_W  512
// longest accepted message, in bits
`define MD5_MSG_W    128
// message length port, counts bits
`define MD5_WIDTH_W  8
// compression steps per block
`define MD5_STEPS    64

// ----------------------------------------
// initial chaining values, rfc 1321
// ----------------------------------------
`define MD5_INIT_A   32'h67452301
`define MD5_INIT_B   32'hefcdab89
`define MD5_INIT_C   32'h98badcfe
`define MD5_INIT_D   32'h10325476

`endif
